// File: design/dmem_ahb_pkg.sv
// --------------------
// Shared definitions for the data-memory to AHB-Lite bridge
// Bus widths and queue depth
// Core and AHB encodings
// Queue entry and data-phase structs
// Byte-lane conversion functions
// --------------------

package dmem_ahb_pkg;

    // Bus and address width
    localparam int DATA_W      = 32;
    localparam int QUEUE_DEPTH = 2;

    // Counts 0 to QUEUE_DEPTH inclusive
    typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_cnt_t;

    // --------------------
    // Core side encodings
    typedef enum logic {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    // --------------------
    // AHB-Lite encodings
    typedef enum logic [2:0] {
        HSIZE_8B  = 3'b000,
        HSIZE_16B = 3'b001,
        HSIZE_32B = 3'b010
    } hsize_e;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_NONSEQ = 2'b10
    } htrans_e;

    localparam logic HRESP_OKAY = 1'b0;

    // One queued request, write data already on its lanes
    typedef struct packed {
        logic              hwrite;
        hsize_e            hsize;
        logic [DATA_W-1:0] haddr;
        logic [DATA_W-1:0] hwdata;
    } ahb_req_t;

    // Only the low address bits matter once the address phase is gone
    typedef struct packed {
        logic              hwrite;
        hsize_e            hsize;
        logic [1:0]        lane;
        logic [DATA_W-1:0] hwdata;
    } data_phase_t;

    // Core width to AHB size
    function automatic hsize_e conv_width(input mem_width_e width);
        hsize_e size;
        case (width)
            MEM_WIDTH_BYTE:  size = HSIZE_8B;
            MEM_WIDTH_HWORD: size = HSIZE_16B;
            default:         size = HSIZE_32B;
        endcase
        return size;
    endfunction

    // Move low byte or halfword up to its lane, other lanes zero
    function automatic logic [DATA_W-1:0] place_wdata(
        input logic [1:0]        lane,
        input mem_width_e        width,
        input logic [DATA_W-1:0] wdata
    );
        logic [DATA_W-1:0] data;
        data = '0;
        case (width)
            MEM_WIDTH_BYTE:  data[8*lane +: 8] = wdata[7:0];
            MEM_WIDTH_HWORD: data[16*lane[1] +: 16] = wdata[15:0];
            default:         data = wdata;
        endcase
        return data;
    endfunction

    // Shift lane down to bit 0, zero extend
    function automatic logic [DATA_W-1:0] extract_rdata(
        input hsize_e            size,
        input logic [1:0]        lane,
        input logic [DATA_W-1:0] rdata
    );
        logic [DATA_W-1:0] data;
        data = '0;
        case (size)
            HSIZE_8B:  data[7:0] = rdata[8*lane +: 8];
            HSIZE_16B: data[15:0] = rdata[16*lane[1] +: 16];
            default:   data = rdata;
        endcase
        return data;
    endfunction

endpackage

// File: design/ahb_req_if.sv
// --------------------
// Queue head handoff between request queue and transfer controller
// Head entry, empty flag and pop strobe
// --------------------

interface ahb_req_if;
    import dmem_ahb_pkg::*;

    // Oldest pending request
    ahb_req_t head;
    // No request pending, head not valid
    logic     empty;
    // One-cycle strobe, drops the head
    logic     pop;

    // Queue side
    modport queue (
        output head,
        output empty,
        input  pop
    );

    // Controller side
    modport ctrl (
        input  head,
        input  empty,
        output pop
    );

endinterface

// File: design/dmem_req_queue.sv
// --------------------
// Two-entry request queue on the core side
// Width to AHB size conversion
// Write data placed on byte lanes at push
// Shift register storage, head at entry 0
// --------------------

module dmem_req_queue (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            dmem_req,
    input  dmem_ahb_pkg::mem_cmd_e          dmem_cmd,
    input  dmem_ahb_pkg::mem_width_e        dmem_width,
    input  logic [dmem_ahb_pkg::DATA_W-1:0] dmem_addr,
    input  logic [dmem_ahb_pkg::DATA_W-1:0] dmem_wdata,
    output logic                            dmem_req_ack,
    ahb_req_if.queue                        req
);
    import dmem_ahb_pkg::*;

    ahb_req_t   entry_q [QUEUE_DEPTH];
    ahb_req_t   entry_d [QUEUE_DEPTH];
    ahb_req_t   new_req;
    queue_cnt_t cnt_q;
    queue_cnt_t cnt_d;
    queue_cnt_t wr_cnt;
    logic       push;

    // --------------------
    // Flags from the count
    assign dmem_req_ack = (cnt_q < queue_cnt_t'(QUEUE_DEPTH));
    assign req.empty    = (cnt_q == '0);
    assign req.head     = entry_q[0];

    // Only back-pressure is a full queue
    assign push = dmem_req & dmem_req_ack;

    // Core request converted to AHB form
    always_comb begin
        new_req.hwrite = (dmem_cmd == MEM_CMD_WR);
        new_req.hsize  = conv_width(dmem_width);
        new_req.haddr  = dmem_addr;
        new_req.hwdata = place_wdata(dmem_addr[1:0], dmem_width, dmem_wdata);
    end

    // --------------------
    // Next queue contents
    always_comb begin
        entry_d = entry_q;
        // Pop moves everything one slot toward the head
        if (req.pop) begin
            for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
                entry_d[i] = entry_q[i+1];
            end
        end
        // Write slot is first free slot after the pop
        wr_cnt = cnt_q - queue_cnt_t'(req.pop);
        if (push) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (queue_cnt_t'(i) == wr_cnt) begin
                    entry_d[i] = new_req;
                end
            end
        end
        cnt_d = wr_cnt + queue_cnt_t'(push);
    end

    // Count, cleared by reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (push || req.pop) begin
            entry_q <= entry_d;
        end
    end

endmodule

// File: design/ahb_xfer_ctrl.sv
// --------------------
// AHB-Lite transfer controller
// Address/data phase FSM
// htrans and pop generation
// Data-phase register for hwdata and response capture
// --------------------

module ahb_xfer_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,
    ahb_req_if.ctrl                         req,
    input  logic                            hready,
    input  logic                            hresp,
    output dmem_ahb_pkg::htrans_e           htrans,
    output logic [dmem_ahb_pkg::DATA_W-1:0] haddr,
    output logic                            hwrite,
    output dmem_ahb_pkg::hsize_e            hsize,
    output logic [dmem_ahb_pkg::DATA_W-1:0] hwdata,
    output logic                            capture,
    output dmem_ahb_pkg::data_phase_t       phase
);
    import dmem_ahb_pkg::*;

    // ADDR: no transfer in data phase
    // DATA: a transfer is in its data phase
    typedef enum logic {
        ST_ADDR = 1'b0,
        ST_DATA = 1'b1
    } state_e;

    state_e      state_q;
    data_phase_t phase_q;
    logic        data_ok;
    logic        issue;

    // Data phase finishing without error
    assign data_ok = hready & (hresp == HRESP_OKAY);

    // --------------------
    // Address phase decision
    always_comb begin
        case (state_q)
            // Idle bus, head goes out at once
            ST_ADDR: issue = ~req.empty;
            // Overlap only when current data phase ends okay
            ST_DATA: issue = ~req.empty & data_ok;
            default: issue = 1'b0;
        endcase
    end

    assign htrans = issue ? HTRANS_NONSEQ : HTRANS_IDLE;

    // Transfer taken at hready, head leaves the queue
    assign req.pop = issue & hready;

    // Current data phase completes
    assign capture = (state_q == ST_DATA) & hready;

    // Address phase signals straight from the head
    assign haddr  = req.head.haddr;
    assign hwrite = req.head.hwrite;
    assign hsize  = req.head.hsize;

    // --------------------
    // State register, moves only on hready
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_ADDR;
        end else if (hready) begin
            // Error or nothing queued falls back to ADDR
            state_q <= issue ? ST_DATA : ST_ADDR;
        end
    end

    // Data-phase register, loaded as the address phase is taken
    always_ff @(posedge clk) begin
        if (req.pop) begin
            phase_q.hwrite <= req.head.hwrite;
            phase_q.hsize  <= req.head.hsize;
            phase_q.lane   <= req.head.haddr[1:0];
            phase_q.hwdata <= req.head.hwdata;
        end
    end

    // Write data follows one cycle behind its address
    assign hwdata = phase_q.hwdata;
    assign phase  = phase_q;

endmodule

// File: design/dmem_resp_stage.sv
// --------------------
// Registered response stage
// Captures status and read data at end of data phase
// Read lane extraction and core response code
// --------------------

module dmem_resp_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            capture,
    input  dmem_ahb_pkg::data_phase_t       phase,
    input  logic                            hresp,
    input  logic [dmem_ahb_pkg::DATA_W-1:0] hrdata,
    output dmem_ahb_pkg::mem_resp_e         dmem_resp,
    output logic [dmem_ahb_pkg::DATA_W-1:0] dmem_rdata
);
    import dmem_ahb_pkg::*;

    logic              valid_q;
    logic              hresp_q;
    hsize_e            size_q;
    logic [1:0]        lane_q;
    logic [DATA_W-1:0] rdata_q;

    // One-cycle valid after each capture
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= capture;
        end
    end

    // Status, lane info and raw read word
    always_ff @(posedge clk) begin
        if (capture) begin
            hresp_q <= hresp;
            size_q  <= phase.hsize;
            lane_q  <= phase.lane;
            rdata_q <= hrdata;
        end
    end

    // --------------------
    // Core side outputs
    always_comb begin
        if (!valid_q) begin
            dmem_resp = MEM_RESP_NOTRDY;
        end else if (hresp_q == HRESP_OKAY) begin
            dmem_resp = MEM_RESP_RDY_OK;
        end else begin
            dmem_resp = MEM_RESP_RDY_ER;
        end
    end

    // Read value shifted down, upper bits zero
    assign dmem_rdata = extract_rdata(size_q, lane_q, rdata_q);

endmodule

// File: design/dmem_ahb_bridge.sv
// --------------------
// Top level of the data-memory to AHB-Lite bridge
// Core port and AHB master port
// Request queue, transfer controller, response stage
// --------------------

module dmem_ahb_bridge (
    input  logic                            clk,
    input  logic                            rst_n,
    // Core data-memory port
    input  logic                            dmem_req,
    input  dmem_ahb_pkg::mem_cmd_e          dmem_cmd,
    input  dmem_ahb_pkg::mem_width_e        dmem_width,
    input  logic [dmem_ahb_pkg::DATA_W-1:0] dmem_addr,
    input  logic [dmem_ahb_pkg::DATA_W-1:0] dmem_wdata,
    output logic                            dmem_req_ack,
    output dmem_ahb_pkg::mem_resp_e         dmem_resp,
    output logic [dmem_ahb_pkg::DATA_W-1:0] dmem_rdata,
    // AHB-Lite master port
    output dmem_ahb_pkg::htrans_e           htrans,
    output logic [dmem_ahb_pkg::DATA_W-1:0] haddr,
    output logic                            hwrite,
    output dmem_ahb_pkg::hsize_e            hsize,
    output logic [dmem_ahb_pkg::DATA_W-1:0] hwdata,
    input  logic                            hready,
    input  logic                            hresp,
    input  logic [dmem_ahb_pkg::DATA_W-1:0] hrdata
);
    import dmem_ahb_pkg::*;

    // Controller to response stage
    logic        capture;
    data_phase_t phase;

    // Queue head handoff
    ahb_req_if req_bus ();

    dmem_req_queue u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .dmem_req     (dmem_req),
        .dmem_cmd     (dmem_cmd),
        .dmem_width   (dmem_width),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_req_ack (dmem_req_ack),
        .req          (req_bus)
    );

    ahb_xfer_ctrl u_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req_bus),
        .hready  (hready),
        .hresp   (hresp),
        .htrans  (htrans),
        .haddr   (haddr),
        .hwrite  (hwrite),
        .hsize   (hsize),
        .hwdata  (hwdata),
        .capture (capture),
        .phase   (phase)
    );

    dmem_resp_stage u_resp (
        .clk        (clk),
        .rst_n      (rst_n),
        .capture    (capture),
        .phase      (phase),
        .hresp      (hresp),
        .hrdata     (hrdata),
        .dmem_resp  (dmem_resp),
        .dmem_rdata (dmem_rdata)
    );

endmodule

// File: sim/dmem_ahb_props.sv
// --------------------
// Bound protocol assertions for the bridge
// Address held through wait states
// Response spacing and ready after reset
// --------------------

module dmem_ahb_props (
    input logic                            clk,
    input logic                            rst_n,
    input dmem_ahb_pkg::htrans_e           htrans,
    input logic [dmem_ahb_pkg::DATA_W-1:0] haddr,
    input logic                            hwrite,
    input dmem_ahb_pkg::hsize_e            hsize,
    input logic                            hready,
    input dmem_ahb_pkg::mem_resp_e         dmem_resp,
    input logic                            dmem_req_ack
);
    import dmem_ahb_pkg::*;

    // Stalled address phase keeps its control
    addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (htrans == HTRANS_NONSEQ && !hready) |=>
            ($stable(haddr) && $stable(hwrite) && $stable(hsize)))
        else $error("address phase changed during a wait state");

    // Back-to-back results need a completed data phase
    resp_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        (dmem_resp != MEM_RESP_NOTRDY && $past(dmem_resp) != MEM_RESP_NOTRDY) |->
            $past(hready))
        else $error("two responses without hready in between");

    // Queue empty right out of reset
    ack_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> dmem_req_ack)
        else $error("dmem_req_ack low after reset");

endmodule

bind dmem_ahb_bridge dmem_ahb_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .htrans       (htrans),
    .haddr        (haddr),
    .hwrite       (hwrite),
    .hsize        (hsize),
    .hready       (hready),
    .dmem_resp    (dmem_resp),
    .dmem_req_ack (dmem_req_ack)
);

// File: sim/tb_dmem_ahb.sv
// --------------------
// Testbench for the data-memory to AHB-Lite bridge
// Clock, reset and AHB-Lite memory slave with random wait states
// Directed tests checked against a reference memory
// In-order response checks and cycle-count timeout
// --------------------

module tb_dmem_ahb;
    import dmem_ahb_pkg::*;

    // 33 requests of up to about 8 cycles each with wide margin
    localparam int MAX_CYCLES = 2000;
    localparam int MEM_WORDS  = 256;

    logic              clk;
    logic              rst_n;
    logic              dmem_req;
    mem_cmd_e          dmem_cmd;
    mem_width_e        dmem_width;
    logic [DATA_W-1:0] dmem_addr;
    logic [DATA_W-1:0] dmem_wdata;
    logic              dmem_req_ack;
    mem_resp_e         dmem_resp;
    logic [DATA_W-1:0] dmem_rdata;
    htrans_e           htrans;
    logic [DATA_W-1:0] haddr;
    logic              hwrite;
    hsize_e            hsize;
    logic [DATA_W-1:0] hwdata;
    logic              hready;
    logic              hresp;
    logic [DATA_W-1:0] hrdata;

    // Slave memory of 1 KB
    logic [DATA_W-1:0] slave_mem [MEM_WORDS];
    // Reference copy kept from the core's point of view
    logic [DATA_W-1:0] ref_mem [MEM_WORDS];

    // Slave data-phase state
    logic              dp_valid;
    logic              dp_write;
    logic              dp_err;
    hsize_e            dp_size;
    logic [DATA_W-1:0] dp_addr;
    logic [1:0]        dp_wait;

    // Expected results in request order
    mem_resp_e         exp_resp [$];
    logic [DATA_W-1:0] exp_rdata [$];
    logic              exp_read [$];

    integer seed = 52;
    int     cycles = 0;
    int     errors;
    int     tests_run;
    int     ack_drops;

    dmem_ahb_bridge u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .dmem_req     (dmem_req),
        .dmem_cmd     (dmem_cmd),
        .dmem_width   (dmem_width),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_req_ack (dmem_req_ack),
        .dmem_resp    (dmem_resp),
        .dmem_rdata   (dmem_rdata),
        .htrans       (htrans),
        .haddr        (haddr),
        .hwrite       (hwrite),
        .hsize        (hsize),
        .hwdata       (hwdata),
        .hready       (hready),
        .hresp        (hresp),
        .hrdata       (hrdata)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d responses missing", cycles, exp_resp.size());
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Every byte of a word tied to its index
    function automatic logic [DATA_W-1:0] fill_word(input int idx);
        return {4{8'(idx)}} ^ 32'h5a3c_0f96;
    endfunction

    function automatic logic [DATA_W-1:0] width_mask(input mem_width_e width);
        case (width)
            MEM_WIDTH_BYTE:  return 32'h0000_00ff;
            MEM_WIDTH_HWORD: return 32'h0000_ffff;
            default:         return 32'hffff_ffff;
        endcase
    endfunction

    // --------------------
    // AHB-Lite slave model
    // Ready on an idle bus or in the last data-phase cycle
    assign hready = ~dp_valid | (dp_wait == 2'd0);
    assign hresp  = dp_valid & dp_err & (dp_wait == 2'd0);
    assign hrdata = (dp_valid && !dp_write && dp_wait == 2'd0) ?
                    slave_mem[dp_addr[9:2]] : '0;

    // Byte enables from size and low address bits
    task automatic store_word(input logic [DATA_W-1:0] addr, input hsize_e size,
                              input logic [DATA_W-1:0] data);
        logic [3:0] be;
        case (size)
            HSIZE_8B:  be = 4'b0001 << addr[1:0];
            HSIZE_16B: be = addr[1] ? 4'b1100 : 4'b0011;
            default:   be = 4'b1111;
        endcase
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                slave_mem[addr[9:2]][8*i +: 8] = data[8*i +: 8];
            end
        end
    endtask

    initial begin : slave_model
        logic              in_rst;
        logic              take;
        logic              done;
        logic              wr;
        hsize_e            sz;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] wdata;
        int                rnd;
        for (int i = 0; i < MEM_WORDS; i++) begin
            slave_mem[i] = fill_word(i);
        end
        dp_valid = 1'b0;
        dp_write = 1'b0;
        dp_err   = 1'b0;
        dp_size  = HSIZE_32B;
        dp_addr  = '0;
        dp_wait  = 2'd0;
        forever begin
            // Bus sampled mid-cycle
            @(negedge clk);
            in_rst = !rst_n;
            take   = (htrans == HTRANS_NONSEQ) && hready;
            done   = dp_valid && hready;
            a      = haddr;
            wr     = hwrite;
            sz     = hsize;
            wdata  = hwdata;
            @(posedge clk);
            #1;
            if (in_rst) begin
                dp_valid = 1'b0;
            end else if (dp_valid && !done) begin
                dp_wait = dp_wait - 2'd1;
            end else begin
                // Bit 12 addresses fail and never write
                if (done && dp_write && !dp_err) begin
                    store_word(dp_addr, dp_size, wdata);
                end
                dp_valid = take;
                if (take) begin
                    dp_addr  = a;
                    dp_write = wr;
                    dp_size  = sz;
                    dp_err   = a[12];
                    rnd      = $random(seed);
                    dp_wait  = rnd[1:0];
                end
            end
        end
    end

    // --------------------
    // Compare tasks
    task automatic check_resp(input string name, input mem_resp_e got, input mem_resp_e exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_rdata(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_htrans(input string name, input htrans_e got, input htrans_e exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // --------------------
    // Checks any response mid-cycle and returns just after the edge
    task automatic step_cycle(output logic ack);
        mem_resp_e         e_resp;
        logic [DATA_W-1:0] e_rdata;
        logic              e_read;
        @(negedge clk);
        ack = dmem_req_ack;
        if (dmem_req && !dmem_req_ack) begin
            ack_drops++;
        end
        if (dmem_resp != MEM_RESP_NOTRDY) begin
            if (exp_resp.size() == 0) begin
                $display("Response returned with no request outstanding");
                errors++;
            end else begin
                e_resp  = exp_resp.pop_front();
                e_rdata = exp_rdata.pop_front();
                e_read  = exp_read.pop_front();
                check_resp("dmem_resp", dmem_resp, e_resp);
                if (e_read) begin
                    check_rdata("dmem_rdata", dmem_rdata, e_rdata);
                end
            end
        end
        @(posedge clk);
        #1;
    endtask

    // Holds dmem_req until accepted and then records the expected result
    task automatic send_req(input mem_cmd_e cmd, input mem_width_e width,
                            input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] wdata);
        logic              ack;
        int                sh;
        logic [DATA_W-1:0] mask;
        logic [7:0]        idx;
        dmem_req   = 1'b1;
        dmem_cmd   = cmd;
        dmem_width = width;
        dmem_addr  = addr;
        dmem_wdata = wdata;
        ack        = 1'b0;
        while (!ack) begin
            step_cycle(ack);
        end
        sh   = 8 * int'(addr[1:0]);
        mask = width_mask(width) << sh;
        idx  = addr[9:2];
        if (addr[12]) begin
            exp_resp.push_back(MEM_RESP_RDY_ER);
            exp_rdata.push_back('0);
            exp_read.push_back(1'b0);
        end else begin
            exp_resp.push_back(MEM_RESP_RDY_OK);
            exp_rdata.push_back((ref_mem[idx] & mask) >> sh);
            exp_read.push_back(cmd == MEM_CMD_RD);
            if (cmd == MEM_CMD_WR) begin
                ref_mem[idx] = (ref_mem[idx] & ~mask) | ((wdata << sh) & mask);
            end
        end
    endtask

    // Drop the request and collect what is outstanding
    task automatic wait_responses;
        logic ack;
        dmem_req = 1'b0;
        while (exp_resp.size() != 0) begin
            step_cycle(ack);
        end
        // One more cycle catches a stray response
        step_cycle(ack);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    // --------------------
    // Directed tests
    task automatic test_reset;
        int e0;
        e0 = errors;
        @(negedge clk);
        check_htrans("htrans", htrans, HTRANS_IDLE);
        check_resp("dmem_resp", dmem_resp, MEM_RESP_NOTRDY);
        check_flag("dmem_req_ack", dmem_req_ack, 1'b1);
        @(posedge clk);
        #1;
        end_test("reset state", e0);
    endtask

    task automatic test_word;
        int e0;
        e0 = errors;
        send_req(MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0000_0100, 32'hdead_beef);
        send_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0100, 32'h0);
        wait_responses();
        end_test("word round trip", e0);
    endtask

    task automatic test_bytes;
        int e0;
        e0 = errors;
        // Upper bits of wdata are junk and must not land
        for (int i = 0; i < 4; i++) begin
            send_req(MEM_CMD_WR, MEM_WIDTH_BYTE, 32'h200 + i, 32'ha5a5_a500 + 32'h11 * (i + 1));
        end
        send_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0200, 32'h0);
        for (int i = 0; i < 4; i++) begin
            send_req(MEM_CMD_RD, MEM_WIDTH_BYTE, 32'h200 + i, 32'h0);
        end
        wait_responses();
        end_test("byte lanes", e0);
    endtask

    task automatic test_hwords;
        int e0;
        e0 = errors;
        send_req(MEM_CMD_WR, MEM_WIDTH_HWORD, 32'h0000_0300, 32'h1234_beef);
        send_req(MEM_CMD_WR, MEM_WIDTH_HWORD, 32'h0000_0302, 32'h5678_cafe);
        send_req(MEM_CMD_RD, MEM_WIDTH_HWORD, 32'h0000_0300, 32'h0);
        send_req(MEM_CMD_RD, MEM_WIDTH_HWORD, 32'h0000_0302, 32'h0);
        send_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0300, 32'h0);
        wait_responses();
        end_test("halfword round trip", e0);
    endtask

    task automatic test_error;
        int e0;
        e0 = errors;
        // 0x1040 aliases byte address 0x040 in the slave so a stray write would show
        send_req(MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0000_1040, 32'hbad0_bad0);
        send_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_1040, 32'h0);
        send_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0040, 32'h0);
        send_req(MEM_CMD_WR, MEM_WIDTH_BYTE, 32'h0000_0041, 32'h0000_0077);
        send_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0040, 32'h0);
        wait_responses();
        end_test("error response", e0);
    endtask

    task automatic test_burst;
        int e0;
        e0 = errors;
        ack_drops = 0;
        // dmem_req stays high from first to last
        send_req(MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0000_0180, 32'h0102_0304);
        send_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0180, 32'h0);
        send_req(MEM_CMD_WR, MEM_WIDTH_BYTE, 32'h0000_0181, 32'hffff_ffee);
        send_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0180, 32'h0);
        send_req(MEM_CMD_WR, MEM_WIDTH_HWORD, 32'h0000_0186, 32'h0000_7788);
        send_req(MEM_CMD_RD, MEM_WIDTH_BYTE, 32'h0000_0187, 32'h0);
        send_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_1184, 32'h0);
        send_req(MEM_CMD_RD, MEM_WIDTH_HWORD, 32'h0000_0186, 32'h0);
        send_req(MEM_CMD_WR, MEM_WIDTH_WORD, 32'h0000_018c, 32'ha5a5_5a5a);
        send_req(MEM_CMD_RD, MEM_WIDTH_BYTE, 32'h0000_018c, 32'h0);
        send_req(MEM_CMD_RD, MEM_WIDTH_HWORD, 32'h0000_0182, 32'h0);
        send_req(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0000_0184, 32'h0);
        wait_responses();
        if (ack_drops == 0) begin
            $display("dmem_req_ack never dropped during back-to-back requests");
            errors++;
        end
        end_test("back-to-back", e0);
    endtask

    // --------------------
    initial begin : main
        rst_n      = 1'b0;
        dmem_req   = 1'b0;
        dmem_cmd   = MEM_CMD_RD;
        dmem_width = MEM_WIDTH_WORD;
        dmem_addr  = '0;
        dmem_wdata = '0;
        errors     = 0;
        tests_run  = 0;
        ack_drops  = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = fill_word(i);
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset();
        test_word();
        test_bytes();
        test_hwords();
        test_error();
        test_burst();

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
design/dmem_ahb_pkg.sv
design/ahb_req_if.sv
design/dmem_req_queue.sv
design/ahb_xfer_ctrl.sv
design/dmem_resp_stage.sv
design/dmem_ahb_bridge.sv
sim/dmem_ahb_props.sv
sim/tb_dmem_ahb.sv

// File: run.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dmem_ahb -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_dmem_ahb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
